/* hw/loopPkg.sv */
`default_nettype none

package loopPkg;

    localparam int ERROR_WIDTH = 8;
    localparam int ACC_WIDTH   = 32;   // accumulator and frequency word
    localparam int EXP_WIDTH   = 5;

    // gain exponent that leaves the error unscaled
    localparam int UNITY_EXP = 7;

    typedef logic signed [ERROR_WIDTH-1:0] errorT;
    typedef logic signed [ACC_WIDTH-1:0]   accT;
    typedef logic        [EXP_WIDTH-1:0]   expT;

endpackage

`default_nettype wire

/* hw/regMapPkg.sv */
`default_nettype none

package regMapPkg;

    localparam int ADDR_WIDTH = 12;
    localparam int DATA_WIDTH = 32;

    // word offsets
    localparam logic [ADDR_WIDTH-1:0] CTRL_ADDR   = 12'h000;
    localparam logic [ADDR_WIDTH-1:0] GAIN_ADDR   = 12'h004;
    localparam logic [ADDR_WIDTH-1:0] LIMIT_ADDR  = 12'h008;
    localparam logic [ADDR_WIDTH-1:0] LOCK_ADDR   = 12'h00C;
    localparam logic [ADDR_WIDTH-1:0] STATUS_ADDR = 12'h010;
    localparam logic [ADDR_WIDTH-1:0] FREQ_ADDR   = 12'h014;

    localparam int INVERT_BIT = 0;
    localparam int ZERO_BIT   = 1;
    localparam int CTRL2_BIT  = 2;

    localparam int LEAD_EXP_LSB = 0;   // gain bits 4..0
    localparam int LAG_EXP_LSB  = 8;   // gain bits 12..8

    localparam int SAT_POS_BIT = 0;
    localparam int SAT_NEG_BIT = 1;
    localparam int LOCKED_BIT  = 2;

    localparam logic [DATA_WIDTH-1:0] LIMIT_RESET = 32'h7FFF_FFFF;

endpackage

`default_nettype wire

/* hw/gainShift.sv */
`default_nettype none
`timescale 1ns/1ps

module gainShift import loopPkg::*; (
    input  wire errorT error,
    input  wire expT   shiftExp,
    output accT        scaled
);

    accT extended;
    expT rightAmount;
    expT leftAmount;

    assign extended = accT'(error);  // sign extend

    // only one of these is meaningful at a time
    assign rightAmount = expT'(UNITY_EXP) - shiftExp;
    assign leftAmount  = shiftExp - expT'(UNITY_EXP);

    always_comb begin
        if (shiftExp < expT'(UNITY_EXP)) begin
            scaled = extended >>> rightAmount;  // floor division
        end else begin
            scaled = extended << leftAmount;    // top bits drop off
        end
    end

endmodule

`default_nettype wire

/* hw/lagIntegrator.sv */
`default_nettype none
`timescale 1ns/1ps

module lagIntegrator import loopPkg::*; (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 clkEn,
    input  wire accT                  lagTerm,
    input  wire logic [ACC_WIDTH-1:0] limit,
    output accT                       accum,
    output logic                      satPos,
    output logic                      satNeg
);

    // one guard bit so the sum never wraps
    logic signed [ACC_WIDTH:0] sum;
    logic signed [ACC_WIDTH:0] upper;
    logic signed [ACC_WIDTH:0] lower;

    assign sum = {accum[ACC_WIDTH-1], accum} + {lagTerm[ACC_WIDTH-1], lagTerm};

    // sign bit of limit is ignored, keeps the window symmetric
    assign upper = {2'b00, limit[ACC_WIDTH-2:0]};
    assign lower = -upper;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            accum  <= '0;
            satPos <= 1'b0;
            satNeg <= 1'b0;
        end else if (clkEn) begin
            if (sum > upper) begin
                accum  <= upper[ACC_WIDTH-1:0];
                satPos <= 1'b1;
                satNeg <= 1'b0;
            end else if (sum < lower) begin
                accum  <= lower[ACC_WIDTH-1:0];
                satPos <= 1'b0;
                satNeg <= 1'b1;
            end else begin
                accum  <= sum[ACC_WIDTH-1:0];
                satPos <= 1'b0;
                satNeg <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/loopFilter.sv */
`default_nettype none
`timescale 1ns/1ps

module loopFilter import loopPkg::*; (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 clkEn,
    input  wire errorT                error,
    input  wire logic                 invertError,
    input  wire logic                 zeroError,
    input  wire expT                  leadExp,
    input  wire expT                  lagExp,
    input  wire logic [ACC_WIDTH-1:0] limit,
    output accT                       loopFreq,
    output logic                      satPos,
    output logic                      satNeg,
    output errorT                     condError
);

    errorT condNext;
    accT   leadScaled;
    accT   lagScaled;
    accT   leadTerm;
    accT   lagTerm;
    accT   leadDelay;
    accT   accum;

    // -128 negates to itself
    always_comb begin
        if (zeroError) begin
            condNext = '0;
        end else if (invertError) begin
            condNext = -error;
        end else begin
            condNext = error;
        end
    end

    gainShift i_leadShift (
        .error    (condError),
        .shiftExp (leadExp),
        .scaled   (leadScaled)
    );

    gainShift i_lagShift (
        .error    (condError),
        .shiftExp (lagExp),
        .scaled   (lagScaled)
    );

    lagIntegrator i_lagIntegrator (
        .clk     (clk),
        .reset   (reset),
        .clkEn   (clkEn),
        .lagTerm (lagTerm),
        .limit   (limit),
        .accum   (accum),
        .satPos  (satPos),
        .satNeg  (satNeg)
    );

    // four strobes from error to loopFreq
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            condError <= '0;
            leadTerm  <= '0;
            lagTerm   <= '0;
            leadDelay <= '0;
            loopFreq  <= '0;
        end else if (clkEn) begin
            condError <= condNext;
            leadTerm  <= leadScaled;
            lagTerm   <= lagScaled;
            leadDelay <= leadTerm;           // lines up with accum
            loopFreq  <= accum + leadDelay;
        end
    end

endmodule

`default_nettype wire

/* hw/lockDetector.sv */
`default_nettype none
`timescale 1ns/1ps

module lockDetector import loopPkg::*; #(
    parameter int LOCK_THRESHOLD = 4
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        clkEn,
    input  wire errorT       condError,
    input  wire logic [15:0] lockCount,
    output logic             locked
);

    logic [ERROR_WIDTH-1:0] magnitude;
    logic                   smallError;
    logic [15:0]            runCount;
    logic [15:0]            runNext;

    // -128 reads back as 128 unsigned
    assign magnitude  = condError[ERROR_WIDTH-1] ? -condError : condError;
    assign smallError = (magnitude <= LOCK_THRESHOLD);

    always_comb begin
        if (!smallError) begin
            runNext = '0;
        end else if (runCount == '1) begin
            runNext = runCount;  // stick at max
        end else begin
            runNext = runCount + 16'd1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            runCount <= '0;
            locked   <= 1'b0;
        end else if (clkEn) begin
            runCount <= runNext;
            locked   <= (lockCount != '0) && (runNext >= lockCount);
        end
    end

endmodule

`default_nettype wire

/* hw/nco.sv */
`default_nettype none
`timescale 1ns/1ps

module nco import loopPkg::*; #(
    parameter int PHASE_WIDTH = 12
) (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             clkEn,
    input  wire accT              freq,
    output logic [PHASE_WIDTH-1:0] phase
);

    logic [ACC_WIDTH-1:0] phaseAcc;

    // wraps mod 2^32, negative freq runs backwards
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phaseAcc <= '0;
        end else if (clkEn) begin
            phaseAcc <= phaseAcc + freq;
        end
    end

    assign phase = phaseAcc[ACC_WIDTH-1 -: PHASE_WIDTH];

endmodule

`default_nettype wire

/* hw/loopRegs.sv */
`default_nettype none
`timescale 1ns/1ps

module loopRegs import loopPkg::*, regMapPkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  cs,
    input  wire logic [ADDR_WIDTH-1:0] addr,
    input  wire logic [DATA_WIDTH-1:0] din,
    input  wire logic                  wr0,
    input  wire logic                  wr1,
    input  wire logic                  wr2,
    input  wire logic                  wr3,
    output logic      [DATA_WIDTH-1:0] dout,
    input  wire logic                  satPos,
    input  wire logic                  satNeg,
    input  wire logic                  locked,
    input  wire accT                   loopFreq,
    output logic                       invertError,
    output logic                       zeroError,
    output logic                       ctrl2,
    output expT                        leadExp,
    output expT                        lagExp,
    output logic      [ACC_WIDTH-1:0]  limit,
    output logic      [15:0]           lockCount
);

    logic [DATA_WIDTH-1:0] ctrlReg;
    logic [DATA_WIDTH-1:0] gainReg;
    logic [DATA_WIDTH-1:0] limitReg;
    logic [DATA_WIDTH-1:0] lockReg;
    logic [DATA_WIDTH-1:0] statusWord;
    logic [3:0]            wrLanes;

    assign wrLanes = {wr3, wr2, wr1, wr0};

    // old value with the strobed bytes replaced
    function automatic logic [DATA_WIDTH-1:0] mergeBytes(
        input logic [DATA_WIDTH-1:0] oldValue,
        input logic [DATA_WIDTH-1:0] data,
        input logic [3:0]            lanes
    );
        logic [DATA_WIDTH-1:0] merged;
        merged = oldValue;
        for (int i = 0; i < 4; i++) begin
            if (lanes[i]) begin
                merged[8*i +: 8] = data[8*i +: 8];
            end
        end
        return merged;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrlReg  <= '0;
            gainReg  <= '0;
            limitReg <= LIMIT_RESET;
            lockReg  <= '0;
        end else if (cs) begin
            case (addr)
                CTRL_ADDR:  ctrlReg  <= mergeBytes(ctrlReg, din, wrLanes);
                GAIN_ADDR:  gainReg  <= mergeBytes(gainReg, din, wrLanes);
                LIMIT_ADDR: limitReg <= mergeBytes(limitReg, din, wrLanes);
                LOCK_ADDR:  lockReg  <= mergeBytes(lockReg, din, wrLanes);
                default: ;  // status and freq are read only
            endcase
        end
    end

    always_comb begin
        statusWord = '0;
        statusWord[SAT_POS_BIT] = satPos;
        statusWord[SAT_NEG_BIT] = satNeg;
        statusWord[LOCKED_BIT]  = locked;
    end

    always_comb begin
        dout = '0;
        if (cs) begin
            case (addr)
                CTRL_ADDR:   dout = ctrlReg;
                GAIN_ADDR:   dout = gainReg;
                LIMIT_ADDR:  dout = limitReg;
                LOCK_ADDR:   dout = lockReg;
                STATUS_ADDR: dout = statusWord;  // live, not latched
                FREQ_ADDR:   dout = loopFreq;
                default:     dout = '0;
            endcase
        end
    end

    assign invertError = ctrlReg[INVERT_BIT];
    assign zeroError   = ctrlReg[ZERO_BIT];
    assign ctrl2       = ctrlReg[CTRL2_BIT];
    assign leadExp     = gainReg[LEAD_EXP_LSB +: EXP_WIDTH];
    assign lagExp      = gainReg[LAG_EXP_LSB +: EXP_WIDTH];
    assign limit       = limitReg;
    assign lockCount   = lockReg[15:0];

endmodule

`default_nettype wire

/* hw/carrierLoop.sv */
`default_nettype none
`timescale 1ns/1ps

module carrierLoop import loopPkg::*, regMapPkg::*; #(
    parameter int PHASE_WIDTH    = 12,
    parameter int LOCK_THRESHOLD = 4
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   clkEn,
    input  wire errorT                  error,
    input  wire logic                   cs,
    input  wire logic [ADDR_WIDTH-1:0]  addr,
    input  wire logic [DATA_WIDTH-1:0]  din,
    input  wire logic                   wr0,
    input  wire logic                   wr1,
    input  wire logic                   wr2,
    input  wire logic                   wr3,
    output logic      [DATA_WIDTH-1:0]  dout,
    output accT                         loopFreq,
    output logic      [PHASE_WIDTH-1:0] phase,
    output logic                        satPos,
    output logic                        satNeg,
    output logic                        locked,
    output logic                        ctrl2,
    output logic      [15:0]            lockCount
);

    logic                 invertError;
    logic                 zeroError;
    expT                  leadExp;
    expT                  lagExp;
    logic [ACC_WIDTH-1:0] limit;
    errorT                condError;

    loopRegs i_loopRegs (
        .clk         (clk),
        .reset       (reset),
        .cs          (cs),
        .addr        (addr),
        .din         (din),
        .wr0         (wr0),
        .wr1         (wr1),
        .wr2         (wr2),
        .wr3         (wr3),
        .dout        (dout),
        .satPos      (satPos),
        .satNeg      (satNeg),
        .locked      (locked),
        .loopFreq    (loopFreq),
        .invertError (invertError),
        .zeroError   (zeroError),
        .ctrl2       (ctrl2),
        .leadExp     (leadExp),
        .lagExp      (lagExp),
        .limit       (limit),
        .lockCount   (lockCount)
    );

    loopFilter i_loopFilter (
        .clk         (clk),
        .reset       (reset),
        .clkEn       (clkEn),
        .error       (error),
        .invertError (invertError),
        .zeroError   (zeroError),
        .leadExp     (leadExp),
        .lagExp      (lagExp),
        .limit       (limit),
        .loopFreq    (loopFreq),
        .satPos      (satPos),
        .satNeg      (satNeg),
        .condError   (condError)
    );

    lockDetector #(
        .LOCK_THRESHOLD (LOCK_THRESHOLD)
    ) i_lockDetector (
        .clk       (clk),
        .reset     (reset),
        .clkEn     (clkEn),
        .condError (condError),
        .lockCount (lockCount),
        .locked    (locked)
    );

    nco #(
        .PHASE_WIDTH (PHASE_WIDTH)
    ) i_nco (
        .clk   (clk),
        .reset (reset),
        .clkEn (clkEn),
        .freq  (loopFreq),
        .phase (phase)
    );

endmodule

`default_nettype wire

/* bench/carrierLoopTb.sv */
`default_nettype none
`timescale 1ns/1ps

module carrierLoopTb
    import loopPkg::*, regMapPkg::*;
();

    localparam int          CLK_PERIOD    = 100;
    localparam int unsigned SEED          = 32'hef76_688e;
    localparam int          PHASE_W       = 12;
    localparam int          LOCK_THR      = 4;
    localparam int          REG_OPS       = 100;
    localparam int          FILTER_PAIRS  = 6;
    localparam int          FILTER_CYCLES = 300;
    localparam int          SAT_READS     = 24;
    localparam int          LOCK_CYCLES   = 400;
    localparam int TEST_LENGTH = REG_OPS * 6 + FILTER_PAIRS * (FILTER_CYCLES + 8)
                               + 2 * SAT_READS * 16 + 2 * LOCK_CYCLES + 40;
    localparam longint TIMEOUT_NS = longint'(TEST_LENGTH * 4 + 1000) * CLK_PERIOD;

    logic                   clk;
    logic                   reset;
    logic                   clkEn;
    errorT                  error;
    logic                   cs;
    logic [ADDR_WIDTH-1:0]  addr;
    logic [DATA_WIDTH-1:0]  din;
    logic                   wr0;
    logic                   wr1;
    logic                   wr2;
    logic                   wr3;
    logic [DATA_WIDTH-1:0]  dout;
    accT                    loopFreq;
    logic [PHASE_W-1:0]     phase;
    logic                   satPos;
    logic                   satNeg;
    logic                   locked;
    logic                   ctrl2;
    logic [15:0]            lockCount;

    logic                   strobesOn;
    int                     errMode;    // 0 random, 1 high, 2 low, 3 lock runs

    // register image and loop model
    logic [31:0] imgCtrl;
    logic [31:0] imgGain;
    logic [31:0] imgLimit;
    logic [31:0] imgLock;
    int          mCond;
    logic [31:0] mLeadTerm;
    logic [31:0] mLagTerm;
    logic [31:0] mLeadDelay;
    logic [31:0] mLoopFreq;
    logic [31:0] mPhaseAcc;
    longint      mAccum;
    logic        mSatPos;
    logic        mSatNeg;
    logic        mLocked;
    int          mRun;
    int          satPosSeen;
    int          satNegSeen;
    int          lockedSeen;

    carrierLoop #(
        .PHASE_WIDTH    (PHASE_W),
        .LOCK_THRESHOLD (LOCK_THR)
    ) i_carrierLoop (
        .clk       (clk),
        .reset     (reset),
        .clkEn     (clkEn),
        .error     (error),
        .cs        (cs),
        .addr      (addr),
        .din       (din),
        .wr0       (wr0),
        .wr1       (wr1),
        .wr2       (wr2),
        .wr3       (wr3),
        .dout      (dout),
        .loopFreq  (loopFreq),
        .phase     (phase),
        .satPos    (satPos),
        .satNeg    (satNeg),
        .locked    (locked),
        .ctrl2     (ctrl2),
        .lockCount (lockCount)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "first mismatch, run stopped");
        end
    endtask

    function automatic logic [31:0] mergeLanes(input logic [31:0] oldValue,
                                               input logic [31:0] data,
                                               input logic [3:0] lanes);
        logic [31:0] mask;
        mask = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
        return (oldValue & ~mask) | (data & mask);
    endfunction

    // error times 2^(exponent - 7) with floor rounding when scaling down
    function automatic logic [31:0] scaleError(input int e, input int exponent);
        int     divisor;
        int     q;
        longint product;
        if (exponent < UNITY_EXP) begin
            divisor = 1 << (UNITY_EXP - exponent);
            q = e / divisor;
            if ((e % divisor != 0) && (e < 0)) begin
                q = q - 1;
            end
            return q;
        end
        product = longint'(e) * (longint'(1) << (exponent - UNITY_EXP));
        return product[31:0];
    endfunction

    function automatic int conditionError(input int e, input logic inv, input logic zero);
        int v;
        if (zero) begin
            return 0;
        end
        v = inv ? -e : e;
        if (v == 128) begin
            v = -128;  // 8-bit wrap
        end
        return v;
    endfunction

    function automatic logic [31:0] imageRead(input logic [ADDR_WIDTH-1:0] a);
        logic [31:0] status;
        status = 32'd0;
        status[SAT_POS_BIT] = mSatPos;
        status[SAT_NEG_BIT] = mSatNeg;
        status[LOCKED_BIT]  = mLocked;
        case (a)
            CTRL_ADDR:   return imgCtrl;
            GAIN_ADDR:   return imgGain;
            LIMIT_ADDR:  return imgLimit;
            LOCK_ADDR:   return imgLock;
            STATUS_ADDR: return status;
            FREQ_ADDR:   return mLoopFreq;
            default:     return 32'd0;
        endcase
    endfunction

    function automatic logic isMapped(input logic [ADDR_WIDTH-1:0] a);
        return a == CTRL_ADDR || a == GAIN_ADDR || a == LIMIT_ADDR
            || a == LOCK_ADDR || a == STATUS_ADDR || a == FREQ_ADDR;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] pickMapped();
        return ADDR_WIDTH'(4 * $urandom_range(5, 0));
    endfunction

    function automatic int nextError();
        int v;
        case (errMode)
            1: v = int'($urandom_range(127, 40));
            2: v = -int'($urandom_range(128, 40));
            3: begin
                if ($urandom_range(7, 0) == 0) begin
                    v = int'($urandom_range(255, 0)) - 128;
                end else begin
                    v = int'($urandom_range(8, 0)) - 4;
                end
            end
            default: v = int'($urandom_range(255, 0)) - 128;
        endcase
        return v;
    endfunction

    task automatic resetModel();
        imgCtrl    = 32'd0;
        imgGain    = 32'd0;
        imgLimit   = 32'h7FFF_FFFF;
        imgLock    = 32'd0;
        mCond      = 0;
        mLeadTerm  = 32'd0;
        mLagTerm   = 32'd0;
        mLeadDelay = 32'd0;
        mLoopFreq  = 32'd0;
        mPhaseAcc  = 32'd0;
        mAccum     = 0;
        mSatPos    = 1'b0;
        mSatNeg    = 1'b0;
        mLocked    = 1'b0;
        mRun       = 0;
    endtask

    // stages advance from the back so each reads the older value
    task automatic advanceModel(input int e);
        longint sum;
        longint lim;
        int     mag;
        mPhaseAcc  = mPhaseAcc + mLoopFreq;
        mLoopFreq  = 32'(mAccum) + mLeadDelay;
        mLeadDelay = mLeadTerm;
        lim = longint'(imgLimit[30:0]);
        sum = mAccum + longint'($signed(mLagTerm));
        mSatPos = 1'b0;
        mSatNeg = 1'b0;
        if (sum > lim) begin
            mAccum  = lim;
            mSatPos = 1'b1;
        end else if (sum < -lim) begin
            mAccum  = -lim;
            mSatNeg = 1'b1;
        end else begin
            mAccum = sum;
        end
        mLeadTerm = scaleError(mCond, int'(imgGain[LEAD_EXP_LSB +: EXP_WIDTH]));
        mLagTerm  = scaleError(mCond, int'(imgGain[LAG_EXP_LSB +: EXP_WIDTH]));
        mag = (mCond < 0) ? -mCond : mCond;
        if (mag > LOCK_THR) begin
            mRun = 0;
        end else if (mRun < 65535) begin
            mRun = mRun + 1;
        end
        mLocked = (imgLock[15:0] != 16'd0) && (mRun >= int'(imgLock[15:0]));
        mCond = conditionError(e, imgCtrl[INVERT_BIT], imgCtrl[ZERO_BIT]);
    endtask

    task automatic applyWrite();
        logic [3:0] lanes;
        lanes = {wr3, wr2, wr1, wr0};
        case (addr)
            CTRL_ADDR:  imgCtrl  = mergeLanes(imgCtrl, din, lanes);
            GAIN_ADDR:  imgGain  = mergeLanes(imgGain, din, lanes);
            LIMIT_ADDR: imgLimit = mergeLanes(imgLimit, din, lanes);
            LOCK_ADDR:  imgLock  = mergeLanes(imgLock, din, lanes);
            default: ;
        endcase
    endtask

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            resetModel();
        end else begin
            if (clkEn) begin
                advanceModel(int'(error));
            end
            if (cs) begin
                applyWrite();
            end
        end
    end

    always @(posedge clk) begin
        clkEn <= !reset && strobesOn && ($urandom_range(1, 0) == 1);
        error <= 8'(nextError());
    end

    // outputs are compared on every falling edge
    always @(negedge clk) begin
        if (!reset) begin
            check("loopFreq", mLoopFreq, loopFreq);
            check("phase", 32'(mPhaseAcc[31 -: PHASE_W]), 32'(phase));
            check("satPos", 32'(mSatPos), 32'(satPos));
            check("satNeg", 32'(mSatNeg), 32'(satNeg));
            check("locked", 32'(mLocked), 32'(locked));
            check("ctrl2 port", 32'(imgCtrl[CTRL2_BIT]), 32'(ctrl2));
            check("lockCount port", 32'(imgLock[15:0]), 32'(lockCount));
            satPosSeen = satPosSeen + int'(satPos);
            satNegSeen = satNegSeen + int'(satNeg);
            lockedSeen = lockedSeen + int'(locked);
        end
    end

    task automatic runCycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic waitStrobe();
        do begin
            @(posedge clk);
        end while (clkEn !== 1'b1);
    endtask

    task automatic writeBus(input logic [ADDR_WIDTH-1:0] a, input logic [31:0] data,
                            input logic [3:0] lanes);
        @(posedge clk);
        cs   <= 1'b1;
        addr <= a;
        din  <= data;
        {wr3, wr2, wr1, wr0} <= lanes;
        @(posedge clk);
        cs <= 1'b0;
        {wr3, wr2, wr1, wr0} <= 4'b0000;
    endtask

    task automatic readBus(input logic [ADDR_WIDTH-1:0] a, output logic [31:0] data);
        @(posedge clk);
        cs   <= 1'b1;
        addr <= a;
        {wr3, wr2, wr1, wr0} <= 4'b0000;
        @(negedge clk);
        data = dout;
    endtask

    // strobes with cs low must neither write nor read
    task automatic idleRead();
        @(posedge clk);
        cs   <= 1'b0;
        addr <= ADDR_WIDTH'($urandom);
        din  <= $urandom;
        {wr3, wr2, wr1, wr0} <= 4'($urandom_range(15, 0));
        @(negedge clk);
        check("read with cs low", 32'd0, dout);
    endtask

    task automatic registerTest();
        logic [31:0]           d;
        logic [ADDR_WIDTH-1:0] a;
        readBus(CTRL_ADDR, d);
        check("reset CTRL", 32'd0, d);
        readBus(GAIN_ADDR, d);
        check("reset GAIN", 32'd0, d);
        readBus(LIMIT_ADDR, d);
        check("reset LIMIT", 32'h7FFF_FFFF, d);
        readBus(LOCK_ADDR, d);
        check("reset LOCK", 32'd0, d);
        readBus(STATUS_ADDR, d);
        check("reset STATUS", 32'd0, d);
        readBus(FREQ_ADDR, d);
        check("reset FREQ", 32'd0, d);
        for (int i = 0; i < REG_OPS; i++) begin
            a = pickMapped();
            writeBus(a, $urandom, 4'($urandom_range(15, 0)));
            readBus(a, d);
            check("register readback", imageRead(a), d);
            do begin
                a = ADDR_WIDTH'($urandom);
            end while (isMapped(a));
            readBus(a, d);
            check("unmapped read", 32'd0, d);
            idleRead();
        end
    endtask

    task automatic filterTest();
        logic [31:0] d;
        logic [31:0] ctrlWord;
        writeBus(LIMIT_ADDR, 32'h7FFF_FFFF, 4'hF);
        strobesOn <= 1'b1;
        for (int p = 0; p < FILTER_PAIRS; p++) begin
            ctrlWord = 32'(p % 4);  // plain, invert, zero, both
            ctrlWord[CTRL2_BIT] = 1'($urandom_range(1, 0));
            writeBus(GAIN_ADDR, {19'($urandom), 5'($urandom), 3'b000, 5'($urandom)}, 4'hF);
            writeBus(CTRL_ADDR, ctrlWord, 4'hF);
            runCycles(FILTER_CYCLES);
            readBus(FREQ_ADDR, d);
            check("FREQ register", imageRead(FREQ_ADDR), d);
        end
    endtask

    task automatic saturationTest();
        logic [31:0] d;
        logic [31:0] smallLimit;
        smallLimit = 32'($urandom_range(4095, 1));
        smallLimit[31] = 1'($urandom_range(1, 0));
        satPosSeen = 0;
        satNegSeen = 0;
        writeBus(LIMIT_ADDR, smallLimit, 4'hF);
        writeBus(GAIN_ADDR, 32'(UNITY_EXP) | (32'($urandom_range(12, 7)) << LAG_EXP_LSB), 4'hF);
        writeBus(CTRL_ADDR, 32'd0, 4'hF);
        for (int dir = 1; dir <= 2; dir++) begin
            errMode <= dir;
            for (int i = 0; i < SAT_READS; i++) begin
                runCycles(15);
                readBus(STATUS_ADDR, d);
                check("STATUS register", imageRead(STATUS_ADDR), d);
            end
        end
        check("upper clamp reached", 32'd1, 32'(satPosSeen > 0));
        check("lower clamp reached", 32'd1, 32'(satNegSeen > 0));
    endtask

    task automatic lockTest();
        logic [31:0] countWord;
        countWord = {16'($urandom), 16'($urandom_range(12, 1))};
        lockedSeen = 0;
        writeBus(LIMIT_ADDR, 32'h7FFF_FFFF, 4'hF);
        writeBus(LOCK_ADDR, countWord, 4'hF);
        errMode <= 3;
        runCycles(LOCK_CYCLES);
        check("lock reached", 32'd1, 32'(lockedSeen > 0));
        writeBus(LOCK_ADDR, 32'd0, 4'hF);
        waitStrobe();
        repeat (LOCK_CYCLES) begin
            @(negedge clk);
            check("locked with zero count", 32'd0, 32'(locked));
        end
        errMode <= 0;
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the tests did not finish in the expected time");
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(SEED));
        clk        = 1'b0;
        reset      = 1'b1;
        clkEn      = 1'b0;
        error      = '0;
        cs         = 1'b0;
        addr       = '0;
        din        = '0;
        wr0        = 1'b0;
        wr1        = 1'b0;
        wr2        = 1'b0;
        wr3        = 1'b0;
        strobesOn  = 1'b0;
        errMode    = 0;
        satPosSeen = 0;
        satNegSeen = 0;
        lockedSeen = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        registerTest();
        filterTest();
        saturationTest();
        lockTest();
        runCycles(8);
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* loopFilter.f */
hw/loopPkg.sv
hw/regMapPkg.sv
hw/gainShift.sv
hw/lagIntegrator.sv
hw/loopFilter.sv
hw/lockDetector.sv
hw/nco.sv
hw/loopRegs.sv
hw/carrierLoop.sv
bench/carrierLoopTb.sv

/* runSim.sh */
#!/bin/sh
# builds the carrier loop testbench with Verilator, runs it, looks for the pass line
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -j 0 \
        --top-module carrierLoopTb -f loopFilter.f \
        -Mdir obj_dir -o carrierLoopSim; then
    echo "verilator build failed"
    exit 1
fi

if output=$(./obj_dir/carrierLoopSim); then
    simStatus=0
else
    simStatus=$?
fi
printf '%s\n' "$output"

if [ "$simStatus" -ne 0 ]; then
    echo "simulation exited with status $simStatus"
fi

if printf '%s\n' "$output" | grep -qx '=== PASS ==='; then
    exit 0
fi
exit 1
